// ==== integrity_pkg.sv ====
////////////////////
// Widths follow a 32-bit OBI request channel with a 12-bit address checksum
// Instruction fetches are taken as full-word reads with fixed attributes
////////////////////
`default_nettype none

package integrity_pkg;

  ////////////////////
  // Bus field widths
  ////////////////////

  // Address and write data are both one 32-bit word
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;

  // One enable bit per byte of write data
  localparam int unsigned BE_W      = 4;
  localparam int unsigned MEMTYPE_W = 2;
  localparam int unsigned PROT_W    = 3;

  // Twelve parity groups make up the address-phase checksum
  localparam int unsigned ACHK_W    = 12;

  // The error counter saturates at its all-ones value
  localparam int unsigned CNT_W     = 8;

  // A fetch always reads the whole word
  localparam logic [BE_W-1:0] INSTR_BE = '1;

  ////////////////////
  // Structured signals
  ////////////////////

  // One request channel as the core drives it in the address phase
  typedef struct packed {
    logic                 req;
    logic                 reqpar;
    logic [ADDR_W-1:0]    addr;
    logic                 we;
    logic [BE_W-1:0]      be;
    logic [MEMTYPE_W-1:0] memtype;
    logic [PROT_W-1:0]    prot;
    logic                 dbg;
    logic [DATA_W-1:0]    wdata;
    logic [ACHK_W-1:0]    achk;
  } obi_req_t;

  // Received and recomputed integrity values of one channel
  // The req bit travels along so the comparison can be qualified later
  typedef struct packed {
    logic              req;
    logic [ACHK_W-1:0] achk_got;
    logic [ACHK_W-1:0] achk_exp;
    logic              reqpar_got;
    logic              reqpar_exp;
  } chk_item_t;

endpackage

`default_nettype wire

// ==== req_sampler.sv ====
////////////////////
// Both channels are captured on every edge without any handshake
// Adds one cycle of latency to the monitor path
////////////////////
`timescale 1ns/1ps
`default_nettype none

module req_sampler (
  input  logic                    clk,
  input  logic                    rst_ni,

  // Request channels straight from the core outputs
  input  integrity_pkg::obi_req_t instr_req_i,
  input  integrity_pkg::obi_req_t data_req_i,

  // Registered copies for the checksum stage
  output integrity_pkg::obi_req_t instr_q_o,
  output integrity_pkg::obi_req_t data_q_o
);

  import integrity_pkg::*;

  ////////////////////
  // Sample registers
  ////////////////////

  // Capture registers for the fetch and the data channel
  obi_req_t instr_q;
  obi_req_t data_q;

  // The instruction channel is sampled whole
  // Its be, we and wdata fields are ignored later by the fetch-side calculator
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_q <= '0;
    end else begin
      instr_q <= instr_req_i;
    end
  end

  // The data channel is sampled every cycle as well
  // An idle cycle still carries a reqpar value that must be checked
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q <= '0;
    end else begin
      data_q <= data_req_i;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  // Cutting the path here keeps the parity trees off the core output timing
  assign instr_q_o = instr_q;
  assign data_q_o  = data_q;

endmodule

`default_nettype wire

// ==== achk_calc.sv ====
////////////////////
// Recomputes achk and reqpar for one channel with one cycle of latency
// INSTR_SIDE replaces be, we and wdata with the fixed fetch values
////////////////////
`timescale 1ns/1ps
`default_nettype none

module achk_calc #(
  // Set for the instruction fetch channel, clear for the data channel
  parameter bit INSTR_SIDE = 1'b0
) (
  input  logic                     clk,
  input  logic                     rst_ni,

  // Registered request from the sampler
  input  integrity_pkg::obi_req_t  req_i,

  // Received and expected integrity values, one cycle later
  output integrity_pkg::chk_item_t item_o
);

  import integrity_pkg::*;

  ////////////////////
  // Effective fields
  ////////////////////

  // Fields that enter the checksum after the fetch substitution
  logic [BE_W-1:0]   be_eff;
  logic              we_eff;
  logic [DATA_W-1:0] wdata_eff;

  // A fetch is a full-word read whatever the port carries
  assign be_eff    = INSTR_SIDE ? INSTR_BE : req_i.be;
  assign we_eff    = INSTR_SIDE ? 1'b0 : req_i.we;
  assign wdata_eff = INSTR_SIDE ? '0 : req_i.wdata;

  ////////////////////
  // Parity groups
  ////////////////////

  // Expected checksum and request parity for this sample
  logic [ACHK_W-1:0] achk_exp;
  logic              reqpar_exp;
  chk_item_t         item_d;
  chk_item_t         item_q;

  // Every checksum bit is the odd parity of its group
  always_comb begin
    achk_exp = '0;
    // Bits 0 to 3 cover the address bytes, lowest byte first
    for (int b = 0; b < ADDR_W / 8; b++) begin
      achk_exp[b] = ~^req_i.addr[8*b +: 8];
    end
    achk_exp[4] = ~^{req_i.prot, req_i.memtype};
    achk_exp[5] = ~^{be_eff, we_eff};
    achk_exp[6] = ~^req_i.dbg;
    // Six reserved zero bits, so this group is always 1
    achk_exp[7] = ~^6'b0;
    // Bits 8 to 11 cover the write data bytes
    for (int b = 0; b < DATA_W / 8; b++) begin
      achk_exp[8 + b] = ~^wdata_eff[8*b +: 8];
    end
  end

  // reqpar is simply the inverse of req
  assign reqpar_exp = ~req_i.req;

  // The received values travel alongside the expected ones
  always_comb begin
    item_d            = '0;
    item_d.req        = req_i.req;
    item_d.achk_got   = req_i.achk;
    item_d.achk_exp   = achk_exp;
    item_d.reqpar_got = req_i.reqpar;
    item_d.reqpar_exp = reqpar_exp;
  end

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      item_q <= '0;
    end else begin
      item_q <= item_d;
    end
  end

  assign item_o = item_q;

endmodule

`default_nettype wire

// ==== alert_collector.sv ====
////////////////////
// Alerts are one-cycle pulses, sticky flags hold until reset
// The error count adds both channels and saturates at its maximum
////////////////////
`timescale 1ns/1ps
`default_nettype none

module alert_collector (
  input  logic                             clk,
  input  logic                             rst_ni,

  // Check items from the two calculators
  input  integrity_pkg::chk_item_t         instr_item_i,
  input  integrity_pkg::chk_item_t         data_item_i,

  // Alert pulses, one per channel
  output logic                             instr_alert_o,
  output logic                             data_alert_o,

  // Flags that stay set after the first alert
  output logic                             instr_sticky_o,
  output logic                             data_sticky_o,

  // Number of alerts seen so far
  output logic [integrity_pkg::CNT_W-1:0]  err_count_o
);

  import integrity_pkg::*;

  ////////////////////
  // Alert rule
  ////////////////////

  // reqpar is checked in every cycle, idle or not
  // The checksum only counts while req is high
  function automatic logic chk_fail(input chk_item_t item);
    logic par_bad;
    logic achk_bad;
    par_bad  = item.reqpar_got != item.reqpar_exp;
    achk_bad = item.req && (item.achk_got != item.achk_exp);
    return par_bad || achk_bad;
  endfunction

  logic instr_fire;
  logic data_fire;

  assign instr_fire = chk_fail(instr_item_i);
  assign data_fire  = chk_fail(data_item_i);

  ////////////////////
  // Saturating count
  ////////////////////

  // One spare bit catches the carry out of the counter
  logic [CNT_W:0]   cnt_sum;
  logic [CNT_W-1:0] cnt_d;
  logic [CNT_W-1:0] cnt_q;

  assign cnt_sum = {1'b0, cnt_q} + CNT_W'(instr_fire) + CNT_W'(data_fire);

  // Clamp to all ones once the sum runs past the counter range
  assign cnt_d = cnt_sum[CNT_W] ? {CNT_W{1'b1}} : cnt_sum[CNT_W-1:0];

  ////////////////////
  // State
  ////////////////////

  logic instr_alert_q;
  logic data_alert_q;
  logic instr_sticky_q;
  logic data_sticky_q;

  // Pulses, flags and count all change at the same edge
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_alert_q  <= 1'b0;
      data_alert_q   <= 1'b0;
      instr_sticky_q <= 1'b0;
      data_sticky_q  <= 1'b0;
      cnt_q          <= '0;
    end else begin
      instr_alert_q  <= instr_fire;
      data_alert_q   <= data_fire;
      // Only reset brings a flag back down
      instr_sticky_q <= instr_sticky_q | instr_fire;
      data_sticky_q  <= data_sticky_q | data_fire;
      cnt_q          <= cnt_d;
    end
  end

  assign instr_alert_o  = instr_alert_q;
  assign data_alert_o   = data_alert_q;
  assign instr_sticky_o = instr_sticky_q;
  assign data_sticky_o  = data_sticky_q;
  assign err_count_o    = cnt_q;

endmodule

`default_nettype wire

// ==== obi_integrity_monitor.sv ====
////////////////////
// Flags an achk or reqpar error three edges after the request is driven
// A new sample is taken every cycle, there is no back-pressure
////////////////////
`timescale 1ns/1ps
`default_nettype none

module obi_integrity_monitor (
  input  logic                            clk,
  input  logic                            rst_ni,

  // Request channels as driven by the core
  input  integrity_pkg::obi_req_t         instr_req_i,
  input  integrity_pkg::obi_req_t         data_req_i,

  // Alert pulses
  output logic                            instr_alert_o,
  output logic                            data_alert_o,

  // Sticky alert flags
  output logic                            instr_sticky_o,
  output logic                            data_sticky_o,

  // Saturating error count
  output logic [integrity_pkg::CNT_W-1:0] err_count_o
);

  import integrity_pkg::*;

  // Sampled requests and per-channel check items
  obi_req_t  instr_q;
  obi_req_t  data_q;
  chk_item_t instr_item;
  chk_item_t data_item;

  ////////////////////
  // Input side
  ////////////////////

  req_sampler u_req_sampler (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .instr_req_i (instr_req_i),
    .data_req_i  (data_req_i),
    .instr_q_o   (instr_q),
    .data_q_o    (data_q)
  );

  ////////////////////
  // Checksum stages
  ////////////////////

  // Fetch side uses the fixed full-word read attributes
  achk_calc #(
    .INSTR_SIDE (1'b1)
  ) u_instr_achk_calc (
    .clk    (clk),
    .rst_ni (rst_ni),
    .req_i  (instr_q),
    .item_o (instr_item)
  );

  achk_calc #(
    .INSTR_SIDE (1'b0)
  ) u_data_achk_calc (
    .clk    (clk),
    .rst_ni (rst_ni),
    .req_i  (data_q),
    .item_o (data_item)
  );

  ////////////////////
  // Output side
  ////////////////////

  alert_collector u_alert_collector (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .instr_item_i   (instr_item),
    .data_item_i    (data_item),
    .instr_alert_o  (instr_alert_o),
    .data_alert_o   (data_alert_o),
    .instr_sticky_o (instr_sticky_o),
    .data_sticky_o  (data_sticky_o),
    .err_count_o    (err_count_o)
  );

endmodule

`default_nettype wire

// ==== tb_obi_integrity_asserts.sv ====
////////////////////
// Bound into alert_collector, reset gates every property
////////////////////
`timescale 1ns/1ps
`default_nettype none

module collector_asserts (
  input logic                            clk,
  input logic                            rst_ni,
  input logic                            instr_alert_o,
  input logic                            data_alert_o,
  input logic                            instr_sticky_o,
  input logic                            data_sticky_o,
  input logic [integrity_pkg::CNT_W-1:0] err_count_o
);

  // Number of failed properties so far
  int unsigned fail_count = 0;

  // Once set, a flag holds until the next reset
  instr_sticky_holds: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_sticky_o |=> instr_sticky_o)
    else begin
      $error("instr sticky flag fell without reset");
      fail_count++;
    end
  data_sticky_holds: assert property (@(posedge clk) disable iff (!rst_ni)
    data_sticky_o |=> data_sticky_o)
    else begin
      $error("data sticky flag fell without reset");
      fail_count++;
    end

  // The counter only counts up or stays saturated
  count_monotonic: assert property (@(posedge clk) disable iff (!rst_ni)
    1'b1 |=> err_count_o >= $past(err_count_o))
    else begin
      $error("error count decreased");
      fail_count++;
    end

  // Pulse and flag are set at the same edge
  instr_alert_sets_sticky: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_alert_o |-> instr_sticky_o)
    else begin
      $error("instr alert without sticky flag");
      fail_count++;
    end
  data_alert_sets_sticky: assert property (@(posedge clk) disable iff (!rst_ni)
    data_alert_o |-> data_sticky_o)
    else begin
      $error("data alert without sticky flag");
      fail_count++;
    end

endmodule

bind alert_collector collector_asserts u_collector_asserts (.*);

`default_nettype wire

// ==== tb_checker.sv ====
////////////////////
// Predicts all five monitor outputs from the sampled requests
// Assumes the fixed 2-cycle latency from sampler capture to alert
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic                            clk,
  input  logic                            rst_ni,
  input  integrity_pkg::obi_req_t         instr_req_i,
  input  integrity_pkg::obi_req_t         data_req_i,
  input  logic                            instr_alert_i,
  input  logic                            data_alert_i,
  input  logic                            instr_sticky_i,
  input  logic                            data_sticky_i,
  input  logic [integrity_pkg::CNT_W-1:0] err_count_i,
  output int                              mismatch_o
);

  import integrity_pkg::*;

  // Checksum from the group rule, fetches use the fixed full-word read attributes
  function automatic logic [ACHK_W-1:0] ref_achk(input obi_req_t r, input bit instr_side);
    logic [BE_W-1:0]   be;
    logic              we;
    logic [DATA_W-1:0] wd;
    logic [ACHK_W-1:0] c;
    be = instr_side ? 4'hf : r.be;
    we = instr_side ? 1'b0 : r.we;
    wd = instr_side ? 32'h0 : r.wdata;
    for (int i = 0; i < 4; i++) begin
      c[i]     = ~^r.addr[8*i +: 8];
      c[8 + i] = ~^wd[8*i +: 8];
    end
    c[4] = ~^{r.prot, r.memtype};
    c[5] = ~^{be, we};
    c[6] = ~r.dbg;
    // Six zero bits have even parity, so the inverted XOR is 1
    c[7] = 1'b1;
    return c;
  endfunction

  // reqpar counts in every cycle, the checksum only while req is high
  function automatic bit predict_alert(input obi_req_t r, input bit instr_side);
    return (r.reqpar !== ~r.req) || (r.req && (r.achk !== ref_achk(r, instr_side)));
  endfunction

  ////////////////////
  // Output model
  ////////////////////

  bit       hist_i [2];
  bit       hist_d [2];
  bit       exp_alert_i;
  bit       exp_alert_d;
  bit       exp_sticky_i;
  bit       exp_sticky_d;
  int       exp_cnt;
  int       mismatch_q;

  assign mismatch_o = mismatch_q;

  initial begin
    mismatch_q = 0;
  end

  // Stage 0 is the sampler word, stage 1 the calculator item
  always @(posedge clk) begin
    if (!rst_ni) begin
      // The sampler clears to an all-zero word, whose reqpar does not match its req
      hist_i[0]    = predict_alert('0, 1'b1);
      hist_d[0]    = predict_alert('0, 1'b0);
      hist_i[1]    = 1'b0;
      hist_d[1]    = 1'b0;
      exp_alert_i  = 1'b0;
      exp_alert_d  = 1'b0;
      exp_sticky_i = 1'b0;
      exp_sticky_d = 1'b0;
      exp_cnt      = 0;
    end else begin
      exp_alert_i  = hist_i[1];
      exp_alert_d  = hist_d[1];
      hist_i[1]    = hist_i[0];
      hist_d[1]    = hist_d[0];
      hist_i[0]    = predict_alert(instr_req_i, 1'b1);
      hist_d[0]    = predict_alert(data_req_i, 1'b0);
      exp_sticky_i = exp_sticky_i | exp_alert_i;
      exp_sticky_d = exp_sticky_d | exp_alert_d;
      exp_cnt      = exp_cnt + int'(exp_alert_i) + int'(exp_alert_d);
      if (exp_cnt > 255) begin
        exp_cnt = 255;
      end
    end
  end

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp) begin
      $display("FAIL %0t %s expected %0h actual %0h", $time, name, exp, got);
      mismatch_q++;
    end
  endtask

  // Outputs settle at the rising edge, so the falling edge sees them stable
  always @(negedge clk) begin
    if (rst_ni) begin
      check_value("instr_alert_o", 8'(exp_alert_i), 8'(instr_alert_i));
      check_value("data_alert_o", 8'(exp_alert_d), 8'(data_alert_i));
      check_value("instr_sticky_o", 8'(exp_sticky_i), 8'(instr_sticky_i));
      check_value("data_sticky_o", 8'(exp_sticky_d), 8'(data_sticky_i));
      check_value("err_count_o", 8'(exp_cnt), err_count_i);
    end
  end

endmodule

`default_nettype wire

// ==== tb_obi_integrity.sv ====
////////////////////
// Runs the request cases in sequence, each drains the pipeline before the next
// The startup alert from the cleared sampler falls in the warm-up window
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_obi_integrity;

  import integrity_pkg::*;

  localparam int WARM_CYC = 6;
  localparam int N_RAND   = 40;
  localparam int CASE_CYC = 5;
  localparam int N_CASES  = 7;
  localparam int SAT_CYC  = 130;
  localparam int LIMIT    = 3 + WARM_CYC + (N_RAND + 3) + N_CASES * CASE_CYC + SAT_CYC + 4 + 50;

  logic             clk;
  logic             rst_ni;
  obi_req_t         instr_req;
  obi_req_t         data_req;
  logic             instr_alert;
  logic             data_alert;
  logic             instr_sticky;
  logic             data_sticky;
  logic [CNT_W-1:0] err_count;
  int               mismatches;
  int               seed;
  int               cycles;
  int               tests_run;
  int               tests_failed;
  int unsigned      assert_fails;

  obi_integrity_monitor dut_i (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req),
    .data_req_i     (data_req),
    .instr_alert_o  (instr_alert),
    .data_alert_o   (data_alert),
    .instr_sticky_o (instr_sticky),
    .data_sticky_o  (data_sticky),
    .err_count_o    (err_count)
  );

  tb_checker u_checker (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req),
    .data_req_i     (data_req),
    .instr_alert_i  (instr_alert),
    .data_alert_i   (data_alert),
    .instr_sticky_i (instr_sticky),
    .data_sticky_i  (data_sticky),
    .err_count_i    (err_count),
    .mismatch_o     (mismatches)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Ends a run that overstays the total length of all tests
  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", LIMIT);
    $display("Test failed");
    $finish;
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Random request with a correct checksum and reqpar
  task automatic rand_req(input bit instr_side, input bit req_v, output obi_req_t r);
    r         = '0;
    r.req     = req_v;
    r.addr    = $random(seed);
    r.we      = $random(seed);
    r.be      = $random(seed);
    r.memtype = $random(seed);
    r.prot    = $random(seed);
    r.dbg     = $random(seed);
    r.wdata   = $random(seed);
    r.achk    = u_checker.ref_achk(r, instr_side);
    r.reqpar  = ~req_v;
  endtask

  task automatic drive(input obi_req_t iw, input obi_req_t dw);
    @(posedge clk);
    #1;
    instr_req = iw;
    data_req  = dw;
  endtask

  task automatic report(input string name, input bit ok, input string why);
    tests_run++;
    if (ok) begin
      $display("%-32s ok", name);
    end else begin
      tests_failed++;
      $display("%-32s FAIL: %s", name, why);
    end
  endtask

  // One sample, then four clean ones; the pulse is due after the third
  task automatic run_case(input string name, input obi_req_t iw, input obi_req_t dw,
                          input bit exp_i, input bit exp_d);
    int       c0;
    int       mm0;
    int       exp_cnt;
    bit       ok;
    string    why;
    obi_req_t ci;
    obi_req_t cd;
    c0  = err_count;
    mm0 = mismatches;
    ok  = 1'b1;
    why = "";
    drive(iw, dw);
    for (int s = 1; s <= 4; s++) begin
      rand_req(1'b1, 1'b1, ci);
      rand_req(1'b0, 1'b1, cd);
      drive(ci, cd);
      if ((s == 3) ? (instr_alert !== exp_i || data_alert !== exp_d)
                   : (instr_alert !== 1'b0 || data_alert !== 1'b0)) begin
        ok  = 1'b0;
        why = "alert pulse missing, early or late";
      end
    end
    exp_cnt = c0 + int'(exp_i) + int'(exp_d);
    if (exp_cnt > 255) begin
      exp_cnt = 255;
    end
    if (err_count != exp_cnt) begin
      ok  = 1'b0;
      why = "error count did not change by the expected amount";
    end
    if ((exp_i && !instr_sticky) || (exp_d && !data_sticky)) begin
      ok  = 1'b0;
      why = "sticky flag not set after an alert";
    end
    if (mismatches != mm0) begin
      ok  = 1'b0;
      why = "checker saw output mismatches";
    end
    report(name, ok, why);
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    obi_req_t iw;
    obi_req_t dw;
    int       c0;
    int       k;
    bit       ok;
    seed         = 32'h7fea_3540;
    tests_run    = 0;
    tests_failed = 0;
    assert_fails = 0;
    rst_ni       = 1'b0;
    instr_req    = '0;
    data_req     = '0;
    instr_req.reqpar = 1'b1;
    data_req.reqpar  = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst_ni = 1'b1;
    for (int s = 0; s < WARM_CYC; s++) begin
      rand_req(1'b1, 1'b0, iw);
      rand_req(1'b0, 1'b0, dw);
      drive(iw, dw);
    end

    // Clean traffic, the trailing idle words drain the pipeline
    c0 = err_count;
    ok = 1'b1;
    for (int s = 0; s < N_RAND + 3; s++) begin
      rand_req(1'b1, (s < N_RAND) ? 1'($random(seed)) : 1'b0, iw);
      rand_req(1'b0, (s < N_RAND) ? 1'($random(seed)) : 1'b0, dw);
      drive(iw, dw);
      if (instr_alert || data_alert) begin
        ok = 1'b0;
      end
    end
    report("clean random traffic", ok && err_count == c0, "alert on correct requests");

    // One flipped checksum bit on the data side
    rand_req(1'b1, 1'b1, iw);
    rand_req(1'b0, 1'b1, dw);
    k = ($random(seed) & 32'h7fff_ffff) % ACHK_W;
    dw.achk[k] = ~dw.achk[k];
    run_case("data achk bit flip", iw, dw, 1'b0, 1'b1);

    // reqpar is checked with req high and low, achk only with req high
    rand_req(1'b1, 1'b1, iw);
    rand_req(1'b0, 1'b1, dw);
    dw.reqpar = ~dw.reqpar;
    run_case("data reqpar error, req high", iw, dw, 1'b0, 1'b1);
    rand_req(1'b1, 1'b0, iw);
    rand_req(1'b0, 1'b1, dw);
    iw.reqpar = ~iw.reqpar;
    run_case("instr reqpar error, req low", iw, dw, 1'b1, 1'b0);
    rand_req(1'b1, 1'b1, iw);
    rand_req(1'b0, 1'b0, dw);
    dw.achk = ~dw.achk;
    run_case("data achk error, req low", iw, dw, 1'b0, 1'b0);

    // The fetch checksum ignores the driven be, we and wdata
    rand_req(1'b1, 1'b1, iw);
    rand_req(1'b0, 1'b1, dw);
    run_case("instr fetch constants", iw, dw, 1'b0, 1'b0);
    rand_req(1'b1, 1'b1, iw);
    iw.wdata[7:0] = 8'h01;
    iw.achk = u_checker.ref_achk(iw, 1'b0);
    run_case("instr achk from driven fields", iw, dw, 1'b1, 1'b0);

    // Both channels at once, then a long run into saturation
    rand_req(1'b1, 1'b1, iw);
    rand_req(1'b0, 1'b1, dw);
    iw.reqpar = ~iw.reqpar;
    dw.reqpar = ~dw.reqpar;
    run_case("both channels in one cycle", iw, dw, 1'b1, 1'b1);
    for (int s = 0; s < SAT_CYC + 4; s++) begin
      rand_req(1'b1, 1'b1, iw);
      rand_req(1'b0, 1'b1, dw);
      if (s < SAT_CYC) begin
        iw.reqpar = ~iw.reqpar;
        dw.reqpar = ~dw.reqpar;
      end
      drive(iw, dw);
    end
    report("count saturation", err_count == 8'hff, "count did not stop at 255");

    assert_fails = dut_i.u_alert_collector.u_collector_asserts.fail_count;
    $display("Tests run: %0d, failed: %0d, output mismatches: %0d, assertion failures: %0d",
             tests_run, tests_failed, mismatches, assert_fails);
    if (tests_failed == 0 && mismatches == 0 && assert_fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
integrity_pkg.sv
req_sampler.sv
achk_calc.sv
alert_collector.sv
obi_integrity_monitor.sv
tb_obi_integrity_asserts.sv
tb_checker.sv
tb_obi_integrity.sv
